//--- compile.f
design/boot_pkg.sv
design/block_counter.sv
design/boot_fsm.sv
design/data_mem.sv
design/instr_mem.sv
design/boot_mem_top.sv
dv/tb_boot_mem.sv

//--- Makefile
# Verilator build and run for the boot memory testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module tb_boot_mem -f compile.f -Mdir obj_dir

run: compile
	./obj_dir/Vtb_boot_mem | tee sim.log
	@grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/tb_boot_mem.sv
// testbench for the boot memory top with a host model, directed tests and a watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_boot_mem
    import boot_pkg::*;
();

    localparam int WATCHDOG_CYCLES = (DM_BLOCKS + IM_BLOCKS) * (BLOCK_WORDS + 8) + 2000;

    localparam host_req_t REQ_IDLE  = '{op: IDLE, addr: 64'h0, data: 32'h0};
    localparam host_rsp_t RSP_NONE  = '{ready: 1'b0, rd_valid: 1'b0, tx_done: 1'b0, data: 32'h0};
    localparam host_rsp_t RSP_READY = '{ready: 1'b1, rd_valid: 1'b0, tx_done: 1'b0, data: 32'h0};
    localparam core_req_t CORE_IDLE = '{rd: 1'b0, wr: 1'b0, addr: 16'h0, wdata: 32'h0};

    logic      clk;
    logic      rst_n;
    host_rsp_t host_rsp;
    addr_t     fetch_addr;
    core_req_t core_req;
    host_req_t host_req;
    word_t     instr;
    word_t     rdata;
    logic      core_hold;

    integer seed;
    int     error_count;
    int     test_start_errors;
    int     tests_run;
    int     tests_failed;

    word_t dm_model [addr_t];  // loaded data words by byte address
    word_t im_model [addr_t];

    boot_mem_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_rsp   (host_rsp),
        .fetch_addr (fetch_addr),
        .core_req   (core_req),
        .host_req   (host_req),
        .instr      (instr),
        .rdata      (rdata),
        .core_hold  (core_hold)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // compare tasks and reporting
    ////////////////////////////////////////////////////////////

    task automatic check_req(input string name, input host_req_t got, input host_req_t exp);
        if (got !== exp) begin
            error_count++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            error_count++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            error_count++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name);
        int errs;
        errs = error_count - test_start_errors;
        tests_run++;
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errs);
        end
        test_start_errors = error_count;
    endtask

    ////////////////////////////////////////////////////////////
    // host and core models
    ////////////////////////////////////////////////////////////

    task automatic wait_for_read();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (host_req.op != READ && cycles < 64) begin
            @(negedge clk);
            cycles++;
        end
        if (host_req.op != READ) begin
            error_count++;
            $display("no READ request from the DUT within %0d cycles", cycles);
        end
    endtask

    // answers one block read, words back to back after a random delay
    task automatic serve_block(input addr_t base, input logic is_im);
        host_req_t exp;
        word_t     w;
        addr_t     a;
        int        delay;
        exp = '{op: READ, addr: 64'(base), data: 32'h0};
        exp.addr[IM_SELECT_BIT] = is_im;
        wait_for_read();
        check_req("host_req", host_req, exp);
        check_bit("core_hold", core_hold, 1'b1);
        delay = $random(seed) & 3;
        repeat (delay) @(posedge clk);
        for (int i = 0; i < BLOCK_WORDS; i++) begin
            @(posedge clk);
            w = $random(seed);
            a = base + addr_t'(4 * i);
            if (is_im) im_model[a] = w;
            else       dm_model[a] = w;
            host_rsp <= '{ready: 1'b1, rd_valid: 1'b1, tx_done: (i == BLOCK_WORDS - 1), data: w};
        end
        @(negedge clk);
        check_req("host_req", host_req, exp);  // held until tx_done
        @(posedge clk);
        host_rsp <= RSP_READY;
    endtask

    task automatic core_read(input addr_t a);
        @(posedge clk);
        core_req <= '{rd: 1'b1, wr: 1'b0, addr: a, wdata: 32'h0};
        @(posedge clk);
        core_req <= CORE_IDLE;
        @(negedge clk);
    endtask

    task automatic core_store(input addr_t a, input word_t d);
        @(posedge clk);
        core_req <= '{rd: 1'b0, wr: 1'b1, addr: a, wdata: d};
        @(posedge clk);
        core_req <= CORE_IDLE;
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic reset_state_test();
        repeat (16) begin
            @(negedge clk);
            check_req("host_req", host_req, REQ_IDLE);
            check_bit("core_hold", core_hold, 1'b1);
        end
        @(posedge clk);
        rst_n <= 1'b1;
        repeat (8) begin  // out of reset, host not ready yet
            @(negedge clk);
            check_req("host_req", host_req, REQ_IDLE);
            check_bit("core_hold", core_hold, 1'b1);
        end
        report_test("reset_state");
    endtask

    task automatic boot_order_test();
        @(posedge clk);
        host_rsp <= RSP_READY;
        for (int b = 0; b < DM_BLOCKS; b++) serve_block(DM_BASES[b], 1'b0);
        for (int b = 0; b < IM_BLOCKS; b++) serve_block(IM_BASES[b], 1'b1);
        @(negedge clk);
        check_bit("core_hold", core_hold, 1'b0);
        check_req("host_req", host_req, REQ_IDLE);
        report_test("boot_order");
    endtask

    task automatic fetch_test();
        addr_t a;
        for (int b = 0; b < IM_BLOCKS; b++) begin
            for (int i = 0; i < BLOCK_WORDS; i++) begin
                a = IM_BASES[b] + addr_t'(4 * i);
                @(posedge clk);
                fetch_addr <= a;
                @(posedge clk);
                @(negedge clk);
                check_word("instr", instr, im_model[a]);
            end
        end
        report_test("instr_fetch");
    endtask

    task automatic data_port_test();
        addr_t a;
        word_t new_word;
        for (int b = 0; b < DM_BLOCKS; b++) begin
            for (int i = 0; i < BLOCK_WORDS; i++) begin
                a = DM_BASES[b] + addr_t'(4 * i);
                core_read(a);
                check_word("rdata", rdata, dm_model[a]);
            end
        end
        new_word = $random(seed);
        core_store(16'h1044, new_word);
        dm_model[16'h1044] = new_word;
        core_read(16'h1044);
        check_word("rdata", rdata, dm_model[16'h1044]);
        report_test("data_port");
    endtask

    task automatic host_write_test();
        host_req_t exp;
        word_t     d;
        int        delay;
        d   = $random(seed);
        exp = '{op: WRITE, addr: 64'h9004, data: d};
        core_store(16'h9004, d);
        @(negedge clk);
        check_req("host_req", host_req, exp);
        check_bit("core_hold", core_hold, 1'b1);
        delay = $random(seed) & 3;
        repeat (delay) begin
            @(negedge clk);
            check_req("host_req", host_req, exp);
            check_bit("core_hold", core_hold, 1'b1);
        end
        @(posedge clk);
        host_rsp <= '{ready: 1'b1, rd_valid: 1'b0, tx_done: 1'b1, data: 32'h0};
        @(negedge clk);
        check_bit("core_hold", core_hold, 1'b1);  // ack not sampled yet
        @(posedge clk);
        host_rsp <= RSP_READY;
        @(negedge clk);
        check_req("host_req", host_req, REQ_IDLE);
        check_bit("core_hold", core_hold, 1'b0);
        // 9004 aliases 1004 in the data memory index
        core_read(16'h1000);
        check_word("rdata", rdata, dm_model[16'h1000]);
        core_read(16'h1004);
        check_word("rdata", rdata, dm_model[16'h1004]);
        report_test("host_write");
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        seed              = 73;
        error_count       = 0;
        test_start_errors = 0;
        tests_run         = 0;
        tests_failed      = 0;
        rst_n      <= 1'b0;
        host_rsp   <= RSP_NONE;
        fetch_addr <= 16'h0;
        core_req   <= CORE_IDLE;

        reset_state_test();
        boot_order_test();
        fetch_test();
        data_port_test();
        host_write_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/boot_mem_top.sv
// boot memory top that joins the boot FSM, block counter and both memories
`timescale 1ns/1ps
`default_nettype none

module boot_mem_top
    import boot_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  host_rsp_t host_rsp,
    input  addr_t     fetch_addr,
    input  core_req_t core_req,
    output host_req_t host_req,
    output word_t     instr,
    output word_t     rdata,
    output logic      core_hold
);

    ////////////////////////////////////////////////////////////
    // boot control
    ////////////////////////////////////////////////////////////

    logic    clear;
    logic    load_base;
    logic    step;
    logic    next_block;
    logic    is_im;
    addr_t   word_addr;
    logic    last_word;
    logic    last_block;
    mem_wr_t dm_wr;
    mem_wr_t im_wr;

    boot_fsm u_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_rsp   (host_rsp),
        .core_req   (core_req),
        .word_addr  (word_addr),
        .last_word  (last_word),
        .last_block (last_block),
        .host_req   (host_req),
        .clear      (clear),
        .load_base  (load_base),
        .step       (step),
        .next_block (next_block),
        .is_im      (is_im),
        .dm_wr      (dm_wr),
        .im_wr      (im_wr),
        .core_hold  (core_hold)
    );

    block_counter u_cnt (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (clear),
        .load_base  (load_base),
        .step       (step),
        .next_block (next_block),
        .is_im      (is_im),
        .word_addr  (word_addr),
        .last_word  (last_word),
        .last_block (last_block)
    );

    ////////////////////////////////////////////////////////////
    // memories
    ////////////////////////////////////////////////////////////

    data_mem u_dmem (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (dm_wr),
        .rd_en   (core_req.rd),
        .rd_addr (core_req.addr),
        .rdata   (rdata)
    );

    instr_mem u_imem (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr         (im_wr),
        .fetch_addr (fetch_addr),
        .instr      (instr)
    );

endmodule

`default_nettype wire

//--- design/instr_mem.sv
// instruction memory with a loader write port and a registered fetch port
`timescale 1ns/1ps
`default_nettype none

module instr_mem
    import boot_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  mem_wr_t wr,
    input  addr_t   fetch_addr,
    output word_t   instr
);

    word_t            mem [IM_DEPTH];
    logic [IM_AW-1:0] fetch_idx;  // fetch register

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr[IM_AW+1:2]] <= wr.data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_idx <= '0;
        end else begin
            fetch_idx <= fetch_addr[IM_AW+1:2];  // every cycle
        end
    end

    assign instr = mem[fetch_idx];

endmodule

`default_nettype wire

//--- design/data_mem.sv
// data memory with one write port and a registered core read port
`timescale 1ns/1ps
`default_nettype none

module data_mem
    import boot_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  mem_wr_t wr,
    input  logic    rd_en,
    input  addr_t   rd_addr,
    output word_t   rdata
);

    word_t             mem [DM_DEPTH];
    logic [DM_AW-1:0]  wr_idx;
    logic [DM_AW-1:0]  rd_idx;

    // word index from byte address
    assign wr_idx = wr.addr[DM_AW+1:2];
    assign rd_idx = rd_addr[DM_AW+1:2];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr_idx] <= wr.data;
        end
    end

    // read data holds until the next read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (rd_en) begin
            rdata <= mem[rd_idx];
        end
    end

endmodule

`default_nettype wire

//--- design/boot_fsm.sv
// boot FSM that loads memory blocks from the host, routes memory writes and forwards host stores
`timescale 1ns/1ps
`default_nettype none

module boot_fsm
    import boot_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  host_rsp_t host_rsp,
    input  core_req_t core_req,
    input  addr_t     word_addr,
    input  logic      last_word,
    input  logic      last_block,
    output host_req_t host_req,
    output logic      clear,
    output logic      load_base,
    output logic      step,
    output logic      next_block,
    output logic      is_im,
    output mem_wr_t   dm_wr,
    output mem_wr_t   im_wr,
    output logic      core_hold
);

    boot_state_t state, next_state;
    logic        im_phase;  // current block goes to instruction memory
    logic        host_hit;
    logic        ld_en;
    mem_wr_t     ld_wr;
    addr_t       blk_base;
    addr_t       hw_addr;   // pending host write
    word_t       hw_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= BOOT_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (state == RUN && host_hit) begin
            hw_addr <= core_req.addr;
            hw_data <= core_req.wdata;
        end
    end

    assign im_phase  = (state == WAIT_IM) || (state == LOAD_IM);
    assign host_hit  = core_req.wr && (core_req.addr >= HOST_BASE);
    assign blk_base  = word_addr & ~BLOCK_MASK;  // bases are block aligned
    assign is_im     = (next_state == WAIT_IM) || (next_state == LOAD_IM);
    assign core_hold = (state != RUN);
    assign ld_wr     = '{en: ld_en, addr: word_addr, data: host_rsp.data};

    ////////////////////////////////////////////////////////////
    // sequencing and counter commands
    ////////////////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        clear      = 1'b0;
        load_base  = 1'b0;
        step       = 1'b0;
        next_block = 1'b0;
        ld_en      = 1'b0;
        case (state)
            BOOT_IDLE: begin
                if (host_rsp.ready) begin
                    clear      = 1'b1;
                    load_base  = 1'b1;
                    next_state = WAIT_DM;
                end
            end
            WAIT_DM, WAIT_IM: begin
                if (host_rsp.rd_valid) begin  // word 0
                    ld_en      = 1'b1;
                    step       = 1'b1;
                    next_state = im_phase ? LOAD_IM : LOAD_DM;
                end
            end
            LOAD_DM, LOAD_IM: begin
                ld_en = host_rsp.rd_valid;
                if (host_rsp.tx_done) begin
                    if (!last_block) begin
                        next_block = 1'b1;
                        load_base  = 1'b1;
                        next_state = im_phase ? WAIT_IM : WAIT_DM;
                    end else if (!im_phase) begin
                        // data tables done, restart on the instruction table
                        clear      = 1'b1;
                        load_base  = 1'b1;
                        next_state = WAIT_IM;
                    end else begin
                        next_state = RUN;
                    end
                end else if (host_rsp.rd_valid && !last_word) begin
                    step = 1'b1;
                end
            end
            RUN: begin
                if (host_hit) next_state = WRT_HOST;
            end
            WRT_HOST: begin
                if (host_rsp.tx_done) next_state = RUN;
            end
            default: next_state = BOOT_IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // host request and memory write ports
    ////////////////////////////////////////////////////////////

    always_comb begin
        host_req = '{op: IDLE, addr: '0, data: '0};
        case (state)
            WAIT_DM, LOAD_DM, WAIT_IM, LOAD_IM: begin
                host_req.op                  = READ;
                host_req.addr                = 64'(blk_base);
                host_req.addr[IM_SELECT_BIT] = im_phase;
            end
            WRT_HOST: begin
                host_req.op   = WRITE;
                host_req.addr = 64'(hw_addr);
                host_req.data = hw_data;
            end
            default: ;
        endcase
    end

    always_comb begin
        dm_wr = '0;
        im_wr = '0;
        if (state == RUN) begin
            dm_wr.en   = core_req.wr && !host_hit;  // local stores only
            dm_wr.addr = core_req.addr;
            dm_wr.data = core_req.wdata;
        end else if (im_phase) begin
            im_wr = ld_wr;
        end else begin
            dm_wr = ld_wr;
        end
    end

endmodule

`default_nettype wire

//--- design/block_counter.sv
// block counter that tracks the block index and steps the load address through each block
`timescale 1ns/1ps
`default_nettype none

module block_counter
    import boot_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  clear,
    input  logic  load_base,
    input  logic  step,
    input  logic  next_block,
    input  logic  is_im,
    output addr_t word_addr,
    output logic  last_word,
    output logic  last_block
);

    logic [BLK_IDX_W-1:0] blk_idx;
    logic [BLK_IDX_W-1:0] blk_idx_nxt;
    logic                 im_tbl;  // table of the loaded base
    addr_t                base;

    // index after this cycle's command, so a base load sees the new block
    always_comb begin
        blk_idx_nxt = blk_idx;
        if (clear) begin
            blk_idx_nxt = '0;
        end else if (next_block) begin
            blk_idx_nxt = blk_idx + 1'b1;
        end
    end

    assign base = is_im ? IM_BASES[blk_idx_nxt] : DM_BASES[blk_idx_nxt];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            blk_idx   <= '0;
            word_addr <= '0;
            im_tbl    <= 1'b0;
        end else begin
            blk_idx <= blk_idx_nxt;
            if (load_base) begin
                word_addr <= base;
                im_tbl    <= is_im;
            end else if (step) begin
                word_addr <= word_addr + addr_t'(4);  // next word
            end
        end
    end

    assign last_word  = (word_addr[WORD_OFF_W+1:2] == WORD_OFF_W'(BLOCK_WORDS - 1));
    assign last_block = im_tbl ? (blk_idx == BLK_IDX_W'(IM_BLOCKS - 1))
                               : (blk_idx == BLK_IDX_W'(DM_BLOCKS - 1));

endmodule

`default_nettype wire

//--- design/boot_pkg.sv
// boot memory package with host link types, block tables and port structs
`default_nettype none

package boot_pkg;

    ////////////////////////////////////////////////////////////
    // widths and sizes
    ////////////////////////////////////////////////////////////

    typedef logic [31:0] word_t;  // data or instruction word
    typedef logic [15:0] addr_t;  // core side byte address

    localparam int BLOCK_WORDS   = 16;
    localparam int DM_BLOCKS     = 4;
    localparam int IM_BLOCKS     = 4;
    localparam int BLK_IDX_W     = $clog2((DM_BLOCKS > IM_BLOCKS) ? DM_BLOCKS : IM_BLOCKS);
    localparam int WORD_OFF_W    = $clog2(BLOCK_WORDS);
    localparam int IM_SELECT_BIT = 16;  // host address bit for instruction blocks

    localparam int DM_DEPTH = 4096;
    localparam int IM_DEPTH = 256;
    localparam int DM_AW    = $clog2(DM_DEPTH);  // core addr bits 13:2
    localparam int IM_AW    = $clog2(IM_DEPTH);  // core addr bits 9:2

    localparam addr_t HOST_BASE  = 16'h9000;  // stores here and above go to the host
    localparam addr_t BLOCK_MASK = addr_t'(BLOCK_WORDS * 4 - 1);

    // block base addresses, loaded in this order
    localparam addr_t DM_BASES [DM_BLOCKS] = '{16'h1000, 16'h1040, 16'h2000, 16'h2040};
    localparam addr_t IM_BASES [IM_BLOCKS] = '{16'h0000, 16'h0040, 16'h0080, 16'h00C0};

    ////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        IDLE  = 2'b00,
        READ  = 2'b01,
        WRITE = 2'b11
    } host_op_t;

    typedef enum logic [2:0] {
        BOOT_IDLE,
        WAIT_DM,
        LOAD_DM,
        WAIT_IM,
        LOAD_IM,
        RUN,
        WRT_HOST
    } boot_state_t;

    ////////////////////////////////////////////////////////////
    // port bundles
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        host_op_t    op;
        logic [63:0] addr;
        word_t       data;
    } host_req_t;

    typedef struct packed {
        logic  ready;
        logic  rd_valid;
        logic  tx_done;  // high with the last word or write ack
        word_t data;
    } host_rsp_t;

    typedef struct packed {
        logic  en;
        addr_t addr;
        word_t data;
    } mem_wr_t;

    typedef struct packed {
        logic  rd;
        logic  wr;
        addr_t addr;
        word_t wdata;
    } core_req_t;

endpackage

`default_nettype wire
